// ==== hw/dekatronPkg.sv ====
package dekatronPkg;

    // ========================================================================
    // digit geometry
    // ========================================================================

    localparam int DEKATRON_WIDTH = 4;      // one bcd digit per tube.
    localparam int AP_DEKATRON_NUM = 5;
    localparam int DATA_DEKATRON_NUM = 3;

    localparam int MEM_DEPTH = 30000;       // cells 0 to 29999.

    // ========================================================================
    // value and bus types
    // ========================================================================

    // digit 0 is the least significant tube.
    typedef logic [AP_DEKATRON_NUM-1:0][DEKATRON_WIDTH-1:0] apValue_t;
    typedef logic [DATA_DEKATRON_NUM-1:0][DEKATRON_WIDTH-1:0] dataValue_t;

    // pointer line to cell memory.
    typedef struct packed {
        apValue_t   addr;
        dataValue_t wdata;
        logic       we;
    } ramReq_t;

endpackage

// ==== hw/dekatronCounter.sv ====
`timescale 1ns/1ns

module dekatronCounter #(
    parameter type valueT = dekatronPkg::dataValue_t,
    parameter valueT TOP_VALUE = '0
) (
    input  logic  Clk,
    input  logic  Rst_n,
    input  logic  hsClk,
    input  logic  Request,
    input  logic  Dec,
    input  logic  Set,
    input  logic  SetZero,
    input  valueT In,
    output logic  Ready,
    output valueT Out,
    output logic  Zero
);
    import dekatronPkg::*;

    localparam int D_NUM = $bits(valueT) / DEKATRON_WIDTH;

    typedef logic [D_NUM-1:0][DEKATRON_WIDTH-1:0] digits_t;

    localparam digits_t TOP_DIGITS = TOP_VALUE;
    localparam logic [DEKATRON_WIDTH-1:0] NINE = DEKATRON_WIDTH'(9);

    // glow walks guide one, guide two, then lands on the main cathode.
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_GUIDE1,
        PH_GUIDE2,
        PH_MAIN
    } phase_t;

    logic [1:0] hsSync;
    logic       hsPrev;
    logic       step;
    phase_t     phase;
    logic       countDown;
    digits_t    value;

    // ========================================================================
    // step clock synchronizer
    // ========================================================================

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            hsSync <= '0;
            hsPrev <= 1'b0;
        end else begin
            hsSync <= {hsSync[0], hsClk};
            hsPrev <= hsSync[1];
        end
    end

    assign step = hsSync[1] & ~hsPrev;    // one Clk per hsClk rise.

    // ========================================================================
    // decimal arithmetic
    // ========================================================================

    function automatic digits_t bcdInc(digits_t v);
        digits_t r;
        logic    carry;
        r = v;
        carry = 1'b1;
        for (int i = 0; i < D_NUM; i++) begin
            if (carry) begin
                if (r[i] == NINE) begin
                    r[i] = '0;                  // carry into next tube.
                end else begin
                    r[i] = r[i] + 1'b1;
                    carry = 1'b0;
                end
            end
        end
        return r;
    endfunction

    function automatic digits_t bcdDec(digits_t v);
        digits_t r;
        logic    borrow;
        r = v;
        borrow = 1'b1;
        for (int i = 0; i < D_NUM; i++) begin
            if (borrow) begin
                if (r[i] == '0) begin
                    r[i] = NINE;
                end else begin
                    r[i] = r[i] - 1'b1;
                    borrow = 1'b0;
                end
            end
        end
        return r;
    endfunction

    // wraps at the limit in both directions.
    function automatic digits_t nextValue(digits_t v, logic down);
        if (down) begin
            return (v == '0) ? TOP_DIGITS : bcdDec(v);
        end
        return (v == TOP_DIGITS) ? digits_t'('0) : bcdInc(v);
    endfunction

    function automatic logic digitsValid(digits_t v);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < D_NUM; i++) begin
            if (v[i] > NINE) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // ========================================================================
    // guide phase FSM
    // ========================================================================

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            phase <= PH_IDLE;
            countDown <= 1'b0;
            value <= '0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (Request) begin
                        if (SetZero) begin
                            value <= '0;
                        end else if (Set) begin
                            value <= In;        // load needs no steps.
                        end else begin
                            countDown <= Dec;
                            phase <= PH_GUIDE1;
                        end
                    end
                end
                PH_GUIDE1: if (step) phase <= PH_GUIDE2;
                PH_GUIDE2: if (step) phase <= PH_MAIN;
                PH_MAIN: begin
                    if (step) begin
                        value <= nextValue(value, countDown);
                        phase <= PH_IDLE;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    assign Ready = (phase == PH_IDLE);
    assign Out = value;
    assign Zero = (value == '0);

    // a loaded or counted tube never shows a non-decimal cathode.
    assert property (@(posedge Clk) disable iff (!Rst_n) digitsValid(value))
        else $error("dekatron digit above nine.");

endmodule

// ==== hw/decimalRam.sv ====
`timescale 1ns/1ns

module decimalRam (
    input  logic                   Clk,
    input  logic                   Rst_n,
    input  dekatronPkg::ramReq_t   ramReq,
    output dekatronPkg::dataValue_t ramData
);
    import dekatronPkg::*;

    localparam int IDX_W = $clog2(MEM_DEPTH);

    dataValue_t       mem [MEM_DEPTH];
    int unsigned      cellIdx;
    logic [IDX_W-1:0] memIdx;
    logic             inRange;

    // weight each tube by its power of ten.
    function automatic int unsigned toIndex(apValue_t a);
        int unsigned acc;
        acc = 0;
        for (int i = AP_DEKATRON_NUM - 1; i >= 0; i--) begin
            acc = acc * 10 + int'(a[i]);
        end
        return acc;
    endfunction

    assign cellIdx = toIndex(ramReq.addr);
    assign inRange = (cellIdx < MEM_DEPTH);
    assign memIdx = cellIdx[IDX_W-1:0];

    assign ramData = inRange ? mem[memIdx] : '0;   // combinational read.

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (ramReq.we && inRange) begin
            mem[memIdx] <= ramReq.wdata;
        end
    end

endmodule

// ==== hw/apLine.sv ====
`timescale 1ns/1ns

module apLine #(
    parameter dekatronPkg::apValue_t   AP_TOP = 20'h29999,
    parameter dekatronPkg::dataValue_t DATA_TOP = 12'h255
) (
    input  logic                    Clk,
    input  logic                    Rst_n,
    input  logic                    hsClk,
    input  logic                    ApRequest,
    input  logic                    DataRequest,
    input  logic                    Dec,
    output logic                    Ready,
    output logic                    ApZero,
    output logic                    DataZero,
    output dekatronPkg::apValue_t   Address,
    output dekatronPkg::dataValue_t Data,
    output dekatronPkg::ramReq_t    ramReq,
    input  dekatronPkg::dataValue_t ramData
);
    import dekatronPkg::*;

    typedef enum logic [3:0] {
        IDLE  = 4'b0001,
        LOAD  = 4'b0010,
        STORE = 4'b0100,
        COUNT = 4'b1000
    } state_t;

    state_t     state;
    logic       apReq;
    logic       dataReq;
    logic       dataSet;
    logic       ramWe;
    logic       memLock;      // cell lives in the data counter.
    logic       opDec;
    logic       apReady;
    logic       dataReady;
    logic       lineIdle;
    logic       dataCtrZero;
    dataValue_t dataCtrOut;

    // ========================================================================
    // counters
    // ========================================================================

    dekatronCounter #(
        .valueT   (apValue_t),
        .TOP_VALUE(AP_TOP)
    ) apCounter (
        .Clk    (Clk),
        .Rst_n  (Rst_n),
        .hsClk  (hsClk),
        .Request(apReq),
        .Dec    (opDec),
        .Set    (1'b0),
        .SetZero(1'b0),
        .In     ('0),
        .Ready  (apReady),
        .Out    (Address),
        .Zero   (ApZero)
    );

    dekatronCounter #(
        .valueT   (dataValue_t),
        .TOP_VALUE(DATA_TOP)
    ) dataCounter (
        .Clk    (Clk),
        .Rst_n  (Rst_n),
        .hsClk  (hsClk),
        .Request(dataReq),
        .Dec    (opDec),
        .Set    (dataSet),
        .SetZero(1'b0),
        .In     (ramData),
        .Ready  (dataReady),
        .Out    (dataCtrOut),
        .Zero   (dataCtrZero)
    );

    assign lineIdle = (state == IDLE) & apReady & dataReady;
    assign Ready = ~ApRequest & ~DataRequest & lineIdle;

    assign Data = memLock ? dataCtrOut : ramData;
    assign DataZero = memLock ? dataCtrZero : (ramData == '0);

    assign ramReq = '{addr: Address, wdata: dataCtrOut, we: ramWe};

    // ========================================================================
    // control FSM
    // ========================================================================

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            state <= IDLE;
            apReq <= 1'b0;
            dataReq <= 1'b0;
            dataSet <= 1'b0;
            ramWe <= 1'b0;
            memLock <= 1'b0;
            opDec <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (ApRequest) begin
                        opDec <= Dec;           // Dec is only held with the request.
                        if (memLock) begin
                            ramWe <= 1'b1;      // write back before moving.
                            state <= STORE;
                        end else begin
                            apReq <= 1'b1;
                            state <= COUNT;
                        end
                    end else if (DataRequest) begin
                        opDec <= Dec;
                        dataReq <= 1'b1;
                        if (!memLock) begin
                            dataSet <= 1'b1;
                            state <= LOAD;
                        end else begin
                            state <= COUNT;
                        end
                    end
                end
                LOAD: begin
                    dataReq <= 1'b0;
                    dataSet <= 1'b0;
                    memLock <= 1'b1;
                    if (!dataReq && dataReady) begin
                        dataReq <= 1'b1;        // cell loaded, now count it.
                        state <= COUNT;
                    end
                end
                STORE: begin
                    ramWe <= 1'b0;
                    memLock <= 1'b0;
                    apReq <= 1'b1;
                    state <= COUNT;
                end
                COUNT: begin
                    apReq <= 1'b0;
                    dataReq <= 1'b0;
                    if (!apReq && !dataReq && apReady && dataReady) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // one command at a time, and only while the whole line is at rest.
    assert property (@(posedge Clk) disable iff (!Rst_n)
        (ApRequest || DataRequest) |-> (lineIdle && !(ApRequest && DataRequest)))
        else $error("pointer line request while busy or both requests high.");

endmodule

// ==== hw/dekatronMachine.sv ====
`timescale 1ns/1ns

module dekatronMachine #(
    parameter dekatronPkg::apValue_t   AP_TOP = 20'h29999,
    parameter dekatronPkg::dataValue_t DATA_TOP = 12'h255
) (
    input  logic                    Clk,
    input  logic                    Rst_n,
    input  logic                    hsClk,
    input  logic                    ApRequest,
    input  logic                    DataRequest,
    input  logic                    Dec,
    output logic                    Ready,
    output logic                    ApZero,
    output logic                    DataZero,
    output dekatronPkg::apValue_t   Address,
    output dekatronPkg::dataValue_t Data
);
    import dekatronPkg::*;

    ramReq_t    ramReq;
    dataValue_t ramData;

    apLine #(
        .AP_TOP  (AP_TOP),
        .DATA_TOP(DATA_TOP)
    ) line (
        .Clk        (Clk),
        .Rst_n      (Rst_n),
        .hsClk      (hsClk),
        .ApRequest  (ApRequest),
        .DataRequest(DataRequest),
        .Dec        (Dec),
        .Ready      (Ready),
        .ApZero     (ApZero),
        .DataZero   (DataZero),
        .Address    (Address),
        .Data       (Data),
        .ramReq     (ramReq),
        .ramData    (ramData)
    );

    decimalRam cellRam (
        .Clk    (Clk),
        .Rst_n  (Rst_n),
        .ramReq (ramReq),
        .ramData(ramData)
    );

endmodule

// ==== test/tbClockGen.sv ====
`timescale 1ns/1ns

module tbClockGen (
    output logic Clk,
    output logic hsClk,
    output logic Rst_n
);

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;          // 10 ns period.
    end

    // step clock, offset so that its edges never meet a Clk edge.
    initial begin
        hsClk = 1'b0;
        #2;
        forever #35 hsClk = ~hsClk;     // 70 ns period.
    end

    initial begin
        Rst_n = 1'b0;
        repeat (10) @(posedge Clk);
        @(negedge Clk);
        Rst_n = 1'b1;
    end

endmodule

// ==== test/tbDekatronMachine.sv ====
`timescale 1ns/1ns

module tbDekatronMachine;
    import dekatronPkg::*;

    localparam int AP_LIMIT = 29999;
    localparam int DATA_LIMIT = 255;
    localparam int READY_TIMEOUT = 200;
    localparam int RESET_TIMEOUT = 50;

    logic       Clk;
    logic       hsClk;
    logic       Rst_n;
    logic       ApRequest;
    logic       DataRequest;
    logic       Dec;
    logic       Ready;
    logic       ApZero;
    logic       DataZero;
    apValue_t   Address;
    dataValue_t Data;

    int          pointer;           // reference model.
    int          cells [MEM_DEPTH];
    int          cycles;
    int unsigned pick;

    tbClockGen clockGen (.Clk(Clk), .hsClk(hsClk), .Rst_n(Rst_n));

    dekatronMachine #(
        .AP_TOP  (20'h29999),
        .DATA_TOP(12'h255)
    ) uut (
        .Clk(Clk), .Rst_n(Rst_n), .hsClk(hsClk),
        .ApRequest(ApRequest), .DataRequest(DataRequest), .Dec(Dec),
        .Ready(Ready), .ApZero(ApZero), .DataZero(DataZero),
        .Address(Address), .Data(Data)
    );

    // ========================================================================
    // checking
    // ========================================================================

    task automatic stopWithFailure(string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    // digit i of the result is the i-th decimal digit of value.
    function automatic logic [19:0] toBcd(int value);
        logic [19:0] r;
        int          rest;
        r = '0;
        rest = value;
        for (int i = 0; i < 5; i++) begin
            r[i*4 +: 4] = 4'(rest % 10);
            rest = rest / 10;
        end
        return r;
    endfunction

    task automatic checkValue(string testName, string what, logic [19:0] expected,
                              logic [19:0] actual);
        assert (actual === expected) else
            stopWithFailure($sformatf("mismatch in %s, %s: expected %h actual %h",
                                      testName, what, expected, actual));
    endtask

    task automatic checkState(string testName);
        checkValue(testName, "Address", toBcd(pointer), 20'(Address));
        checkValue(testName, "Data", toBcd(cells[pointer]), 20'(Data));
        checkValue(testName, "ApZero", 20'(pointer == 0), 20'(ApZero));
        checkValue(testName, "DataZero", 20'(cells[pointer] == 0), 20'(DataZero));
    endtask

    // ========================================================================
    // stimulus
    // ========================================================================

    task automatic updateModel(logic isAp, logic down);
        if (isAp) begin
            if (down) pointer = (pointer == 0) ? AP_LIMIT : pointer - 1;
            else pointer = (pointer == AP_LIMIT) ? 0 : pointer + 1;
        end else if (down) begin
            cells[pointer] = (cells[pointer] == 0) ? DATA_LIMIT : cells[pointer] - 1;
        end else begin
            cells[pointer] = (cells[pointer] == DATA_LIMIT) ? 0 : cells[pointer] + 1;
        end
    endtask

    task automatic waitForReady(string testName);
        int waited;
        waited = 0;
        while (!Ready && waited < READY_TIMEOUT) begin
            @(negedge Clk);
            waited++;
        end
        if (!Ready) stopWithFailure($sformatf("Ready never returned in %s", testName));
    endtask

    // called on a falling edge with Ready high.
    task automatic runOp(string testName, logic isAp, logic down);
        ApRequest = isAp;
        DataRequest = !isAp;
        Dec = down;
        @(negedge Clk);
        ApRequest = 1'b0;
        DataRequest = 1'b0;
        Dec = 1'b0;
        waitForReady(testName);
        updateModel(isAp, down);
        checkState(testName);
    endtask

    initial begin
        ApRequest = 1'b0;
        DataRequest = 1'b0;
        Dec = 1'b0;
        void'($urandom(539));
        pointer = 0;
        for (int i = 0; i < MEM_DEPTH; i++) cells[i] = 0;

        cycles = 0;
        while (Rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(negedge Clk);
            cycles++;
        end
        if (Rst_n !== 1'b1) stopWithFailure("reset was never released");
        @(negedge Clk);

        checkValue("reset", "Ready", 20'd1, 20'(Ready));
        checkState("reset");

        repeat (12) runOp("data increments", 1'b0, 1'b0);
        checkValue("data increments", "Data", toBcd(12), 20'(Data));
        repeat (12) runOp("data decrements", 1'b0, 1'b1);

        runOp("data wrap down", 1'b0, 1'b1);
        checkValue("data wrap down", "Data", toBcd(255), 20'(Data));
        runOp("data wrap up", 1'b0, 1'b0);
        runOp("pointer wrap down", 1'b1, 1'b1);
        checkValue("pointer wrap down", "Address", toBcd(29999), 20'(Address));
        runOp("pointer wrap up", 1'b1, 1'b0);

        // cell 0 holds 7 and cell 1 holds 3 after this block.
        repeat (7) runOp("write-back", 1'b0, 1'b0);
        runOp("write-back", 1'b1, 1'b0);
        checkValue("write-back move up", "Data", toBcd(0), 20'(Data));
        repeat (3) runOp("write-back", 1'b0, 1'b0);
        runOp("write-back", 1'b1, 1'b1);
        checkValue("write-back move down", "Data", toBcd(7), 20'(Data));
        runOp("write-back", 1'b1, 1'b0);
        checkValue("write-back move up again", "Data", toBcd(3), 20'(Data));

        for (int n = 0; n < 300; n++) begin
            pick = $urandom;
            runOp($sformatf("random %0d", n), pick[0], pick[1]);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== all.f ====
hw/dekatronPkg.sv
hw/dekatronCounter.sv
hw/decimalRam.sv
hw/apLine.sv
hw/dekatronMachine.sv
test/tbClockGen.sv
test/tbDekatronMachine.sv

// ==== run.sh ====
#!/bin/sh
# build the dekatron machine testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tbDekatronMachine \
    -f all.f \
    -o simDekatron

# the simulator exits non-zero on $fatal, so the log decides the result.
./obj_dir/simDekatron > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
    exit 1
fi
if ! grep -qF '*** PASSED ***' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
